// File: src/gpu_cfg_pkg.sv
package gpu_cfg_pkg;

    // core sizing
    localparam int num_threads  = 4;
    localparam int num_warps    = 4;
    localparam int num_barriers = 4;

    localparam int nw_bits = $clog2(num_warps);
    localparam int nb_bits = $clog2(num_barriers);
    localparam int nr_bits = 5;

    // data and pc words
    typedef logic [31:0] word_t;

    typedef logic [nw_bits-1:0] wid_t;

    // one bit per lane
    typedef logic [num_threads-1:0] tmask_t;

    // one bit per warp
    typedef logic [num_warps-1:0] wmask_t;

    typedef logic [nb_bits-1:0] bar_id_t;

    // destination register index
    typedef logic [nr_bits-1:0] reg_t;

endpackage

// File: src/gpu_op_pkg.sv
package gpu_op_pkg;

    localparam int op_bits = 2;

    // warp-control opcodes from issue
    typedef enum logic [op_bits-1:0] {
        op_tmc    = 2'd0,
        op_wspawn = 2'd1,
        op_split  = 2'd2,
        op_bar    = 2'd3
    } gpu_op_e;

    // barrier size minus one, counts warps
    localparam int size_bits = gpu_cfg_pkg::nw_bits;

    typedef logic [size_bits-1:0] bar_size_t;

    // start pc of warp 0
    localparam gpu_cfg_pkg::word_t reset_pc = 32'h8000_0000;

endpackage

// File: src/gpu_unit.sv
`timescale 1ns/1ps

module gpu_unit (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   req_valid,
    output logic                   req_ready,
    input  gpu_cfg_pkg::wid_t      req_wid,
    input  gpu_cfg_pkg::tmask_t    req_tmask,
    input  gpu_cfg_pkg::word_t     req_pc,
    input  gpu_cfg_pkg::word_t     req_next_pc,
    input  gpu_op_pkg::gpu_op_e    req_op,
    input  gpu_cfg_pkg::reg_t      req_rd,
    input  logic                   req_wb,
    input  gpu_cfg_pkg::word_t     req_rs1,
    input  gpu_cfg_pkg::tmask_t    req_cond,
    input  gpu_cfg_pkg::word_t     req_rs2,

    output logic                   cmt_valid,
    input  logic                   cmt_ready,
    output gpu_cfg_pkg::wid_t      cmt_wid,
    output gpu_cfg_pkg::tmask_t    cmt_tmask,
    output gpu_cfg_pkg::word_t     cmt_pc,
    output gpu_cfg_pkg::reg_t      cmt_rd,
    output logic                   cmt_wb,

    output logic                   ctl_valid,
    output gpu_cfg_pkg::wid_t      ctl_wid,
    output logic                   tmc_valid,
    output gpu_cfg_pkg::tmask_t    tmc_mask,
    output logic                   wspawn_valid,
    output gpu_cfg_pkg::wmask_t    wspawn_wmask,
    output gpu_cfg_pkg::word_t     wspawn_pc,
    output logic                   split_valid,
    output logic                   split_diverged,
    output gpu_cfg_pkg::tmask_t    split_then,
    output gpu_cfg_pkg::tmask_t    split_else,
    output gpu_cfg_pkg::word_t     split_pc,
    output logic                   bar_valid,
    output gpu_cfg_pkg::bar_id_t   bar_id,
    output gpu_op_pkg::bar_size_t  bar_size_m1
);

    logic                  is_tmc;
    logic                  is_wspawn;
    logic                  is_split;
    logic                  is_bar;
    logic                  stall;
    gpu_cfg_pkg::tmask_t   tmc_mask_d;
    gpu_cfg_pkg::wmask_t   wspawn_wmask_d;
    gpu_cfg_pkg::tmask_t   then_d;
    gpu_cfg_pkg::tmask_t   else_d;

    assign is_tmc    = (req_op == gpu_op_pkg::op_tmc);
    assign is_wspawn = (req_op == gpu_op_pkg::op_wspawn);
    assign is_split  = (req_op == gpu_op_pkg::op_split);
    assign is_bar    = (req_op == gpu_op_pkg::op_bar);

    // lane masks for tmc and split
    always_comb begin
        for (int i = 0; i < gpu_cfg_pkg::num_threads; i++) begin
            tmc_mask_d[i] = (32'(i) < req_rs1);
            then_d[i]     = req_tmask[i] & req_cond[i];
            else_d[i]     = req_tmask[i] & ~req_cond[i];
        end
    end

    always_comb begin
        for (int i = 0; i < gpu_cfg_pkg::num_warps; i++) begin
            wspawn_wmask_d[i] = (32'(i) < req_rs1);
        end
    end

    // hold the record while commit is blocked
    assign stall     = cmt_valid & ~cmt_ready;
    assign req_ready = ~stall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmt_valid    <= 1'b0;
            tmc_valid    <= 1'b0;
            wspawn_valid <= 1'b0;
            split_valid  <= 1'b0;
            bar_valid    <= 1'b0;
        end else if (!stall) begin
            cmt_valid    <= req_valid;
            tmc_valid    <= req_valid & is_tmc;
            wspawn_valid <= req_valid & is_wspawn;
            split_valid  <= req_valid & is_split;
            bar_valid    <= req_valid & is_bar;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            cmt_wid        <= req_wid;
            cmt_tmask      <= req_tmask;
            cmt_pc         <= req_pc;
            cmt_rd         <= req_rd;
            cmt_wb         <= req_wb;
            tmc_mask       <= tmc_mask_d;
            wspawn_wmask   <= wspawn_wmask_d;
            wspawn_pc      <= req_rs2;
            split_diverged <= (|then_d) && (|else_d);
            split_then     <= then_d;
            split_else     <= else_d;
            split_pc       <= req_next_pc;
            bar_id         <= req_rs1[gpu_cfg_pkg::nb_bits-1:0];
            bar_size_m1    <= gpu_op_pkg::bar_size_t'(req_rs2 - 32'd1);
        end
    end

    // control record applies only when commit fires
    assign ctl_valid = cmt_valid & cmt_ready;
    assign ctl_wid   = cmt_wid;

    a_hold_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (cmt_valid && !cmt_ready) |=> (cmt_valid
            && $stable({cmt_wid, cmt_tmask, cmt_pc, cmt_rd, cmt_wb}))
    );

endmodule

// File: src/warp_state.sv
`timescale 1ns/1ps

module warp_state (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  ctl_valid,
    input  gpu_cfg_pkg::wid_t     ctl_wid,
    input  logic                  tmc_valid,
    input  gpu_cfg_pkg::tmask_t   tmc_mask,
    input  logic                  wspawn_valid,
    input  gpu_cfg_pkg::wmask_t   wspawn_wmask,
    input  gpu_cfg_pkg::word_t    wspawn_pc,
    input  logic                  split_valid,
    input  logic                  split_diverged,
    input  gpu_cfg_pkg::tmask_t   split_then,
    input  gpu_cfg_pkg::tmask_t   split_else,
    input  gpu_cfg_pkg::word_t    split_pc,

    input  gpu_cfg_pkg::wmask_t   stalled,

    input  gpu_cfg_pkg::wid_t     sched_wid,
    output logic                  sched_active,
    output gpu_cfg_pkg::tmask_t   sched_tmask,
    output gpu_cfg_pkg::word_t    sched_pc
);

    gpu_cfg_pkg::wmask_t  active;
    gpu_cfg_pkg::wmask_t  else_valid;
    gpu_cfg_pkg::tmask_t  tmask     [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::word_t   pc        [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::tmask_t  else_mask [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::word_t   else_pc   [gpu_cfg_pkg::num_warps];
    logic                 reconverge;
    logic                 diverge;

    // tmc 0 with a saved else side switches over instead of stopping
    assign reconverge = tmc_valid && (tmc_mask == '0) && else_valid[ctl_wid];
    assign diverge    = split_valid && split_diverged;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active     <= gpu_cfg_pkg::wmask_t'(1);
            else_valid <= '0;
            for (int i = 0; i < gpu_cfg_pkg::num_warps; i++) begin
                tmask[i] <= '0;
                pc[i]    <= '0;
            end
            tmask[0] <= '1;
            pc[0]    <= gpu_op_pkg::reset_pc;
        end else if (ctl_valid) begin
            if (wspawn_valid) begin
                for (int i = 0; i < gpu_cfg_pkg::num_warps; i++) begin
                    if (wspawn_wmask[i] && (gpu_cfg_pkg::wid_t'(i) != ctl_wid)) begin
                        // spawned warps start on lane 0 only
                        active[i] <= 1'b1;
                        tmask[i]  <= gpu_cfg_pkg::tmask_t'(1);
                        pc[i]     <= wspawn_pc;
                    end
                end
            end else if (reconverge) begin
                tmask[ctl_wid]      <= else_mask[ctl_wid];
                pc[ctl_wid]         <= else_pc[ctl_wid];
                else_valid[ctl_wid] <= 1'b0;
            end else if (tmc_valid) begin
                active[ctl_wid] <= |tmc_mask;
                tmask[ctl_wid]  <= tmc_mask;
            end else if (diverge) begin
                tmask[ctl_wid]      <= split_then;
                else_valid[ctl_wid] <= 1'b1;
            end
        end
    end

    // else side of a split, one deep
    always_ff @(posedge clk) begin
        if (ctl_valid && diverge) begin
            else_mask[ctl_wid] <= split_else;
            else_pc[ctl_wid]   <= split_pc;
        end
    end

    // read port for the scheduler
    assign sched_active = active[sched_wid] & ~stalled[sched_wid];
    assign sched_tmask  = tmask[sched_wid];
    assign sched_pc     = pc[sched_wid];

    a_no_nested_split: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ctl_valid && diverge) |-> !else_valid[ctl_wid]
    );

endmodule

// File: src/barrier_table.sv
`timescale 1ns/1ps

module barrier_table (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   ctl_valid,
    input  gpu_cfg_pkg::wid_t      ctl_wid,
    input  logic                   bar_valid,
    input  gpu_cfg_pkg::bar_id_t   bar_id,
    input  gpu_op_pkg::bar_size_t  bar_size_m1,

    output gpu_cfg_pkg::wmask_t    stalled
);

    gpu_op_pkg::bar_size_t  count   [gpu_cfg_pkg::num_barriers];
    gpu_cfg_pkg::wmask_t    waiting [gpu_cfg_pkg::num_barriers];
    logic                   arrive;
    logic                   bar_done;

    assign arrive   = ctl_valid && bar_valid;

    // last warp in releases the whole group
    assign bar_done = (count[bar_id] == bar_size_m1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int b = 0; b < gpu_cfg_pkg::num_barriers; b++) begin
                count[b]   <= '0;
                waiting[b] <= '0;
            end
        end else if (arrive) begin
            if (bar_done) begin
                count[bar_id]   <= '0;
                waiting[bar_id] <= '0;
            end else begin
                count[bar_id]            <= count[bar_id] + 1'b1;
                waiting[bar_id][ctl_wid] <= 1'b1;
            end
        end
    end

    always_comb begin
        stalled = '0;
        for (int b = 0; b < gpu_cfg_pkg::num_barriers; b++) begin
            stalled = stalled | waiting[b];
        end
    end

    // a warp parks at one barrier at most
    for (genvar a = 0; a < gpu_cfg_pkg::num_barriers; a++) begin : g_bar_a
        for (genvar b = a + 1; b < gpu_cfg_pkg::num_barriers; b++) begin : g_bar_b
            a_single_wait: assert property (
                @(posedge clk) disable iff (!rst_n)
                (waiting[a] & waiting[b]) == '0
            );
        end
    end

endmodule

// File: src/gpu_ctl_top.sv
`timescale 1ns/1ps

module gpu_ctl_top (
    input  logic                 clk,
    input  logic                 rst_n,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  gpu_cfg_pkg::wid_t    req_wid,
    input  gpu_cfg_pkg::tmask_t  req_tmask,
    input  gpu_cfg_pkg::word_t   req_pc,
    input  gpu_cfg_pkg::word_t   req_next_pc,
    input  gpu_op_pkg::gpu_op_e  req_op,
    input  gpu_cfg_pkg::reg_t    req_rd,
    input  logic                 req_wb,
    input  gpu_cfg_pkg::word_t   req_rs1,
    input  gpu_cfg_pkg::tmask_t  req_cond,
    input  gpu_cfg_pkg::word_t   req_rs2,

    output logic                 cmt_valid,
    input  logic                 cmt_ready,
    output gpu_cfg_pkg::wid_t    cmt_wid,
    output gpu_cfg_pkg::tmask_t  cmt_tmask,
    output gpu_cfg_pkg::word_t   cmt_pc,
    output gpu_cfg_pkg::reg_t    cmt_rd,
    output logic                 cmt_wb,

    input  gpu_cfg_pkg::wid_t    sched_wid,
    output logic                 sched_active,
    output gpu_cfg_pkg::tmask_t  sched_tmask,
    output gpu_cfg_pkg::word_t   sched_pc
);

    // control bus from commit
    logic                   ctl_valid;
    gpu_cfg_pkg::wid_t      ctl_wid;
    logic                   tmc_valid;
    gpu_cfg_pkg::tmask_t    tmc_mask;
    logic                   wspawn_valid;
    gpu_cfg_pkg::wmask_t    wspawn_wmask;
    gpu_cfg_pkg::word_t     wspawn_pc;
    logic                   split_valid;
    logic                   split_diverged;
    gpu_cfg_pkg::tmask_t    split_then;
    gpu_cfg_pkg::tmask_t    split_else;
    gpu_cfg_pkg::word_t     split_pc;
    logic                   bar_valid;
    gpu_cfg_pkg::bar_id_t   bar_id;
    gpu_op_pkg::bar_size_t  bar_size_m1;

    gpu_cfg_pkg::wmask_t    stalled;

    gpu_unit gpu_unit_inst (.*);

    warp_state warp_state_inst (.*);

    barrier_table barrier_table_inst (.*);

endmodule

// File: dv/gpu_ctl_tb.sv
`timescale 1ns/1ps

module gpu_ctl_tb;

    // test lengths in clock cycles
    localparam int len_reset = 20;
    localparam int len_tmc   = 90;
    localparam int len_spawn = 20;
    localparam int len_split = 40;
    localparam int len_bar   = 30;
    localparam int len_bp    = 130;
    localparam int len_total = 2 + len_reset + len_tmc + len_spawn + len_split + len_bar + len_bp;

    logic clk;
    logic rst_n;
    logic req_valid;
    logic req_ready;
    logic req_wb;
    logic cmt_valid;
    logic cmt_ready;
    logic cmt_wb;
    logic sched_active;
    gpu_cfg_pkg::wid_t req_wid;
    gpu_cfg_pkg::wid_t cmt_wid;
    gpu_cfg_pkg::wid_t sched_wid;
    gpu_cfg_pkg::tmask_t req_tmask;
    gpu_cfg_pkg::tmask_t req_cond;
    gpu_cfg_pkg::tmask_t cmt_tmask;
    gpu_cfg_pkg::tmask_t sched_tmask;
    gpu_cfg_pkg::word_t req_pc;
    gpu_cfg_pkg::word_t req_next_pc;
    gpu_cfg_pkg::word_t req_rs1;
    gpu_cfg_pkg::word_t req_rs2;
    gpu_cfg_pkg::word_t cmt_pc;
    gpu_cfg_pkg::word_t sched_pc;
    gpu_cfg_pkg::reg_t req_rd;
    gpu_cfg_pkg::reg_t cmt_rd;
    gpu_op_pkg::gpu_op_e req_op;

    // reference model of warp and barrier state
    logic m_active [gpu_cfg_pkg::num_warps];
    logic m_else_valid [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::tmask_t m_tmask [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::tmask_t m_else_mask [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::word_t m_pc [gpu_cfg_pkg::num_warps];
    gpu_cfg_pkg::word_t m_else_pc [gpu_cfg_pkg::num_warps];
    gpu_op_pkg::bar_size_t m_count [gpu_cfg_pkg::num_barriers];
    gpu_cfg_pkg::wmask_t m_wait [gpu_cfg_pkg::num_barriers];

    // accepted records as {wid, tmask, pc, rd, wb}
    logic [43:0] cmt_q [$];
    logic [43:0] exp_cmt;
    logic exp_pending;
    int n_done;
    logic cmt_fire;
    logic chk_sched;
    logic exp_active;
    gpu_cfg_pkg::tmask_t exp_tmask;
    gpu_cfg_pkg::word_t exp_pc;
    logic gaps;
    int err_count;
    int tests_passed;
    int tests_failed;

    gpu_ctl_top gpu_ctl_top_inst (.*);

    always #20 clk = ~clk;

    assign cmt_fire = cmt_valid & cmt_ready;

    always @(negedge clk) begin
        if (gaps) begin
            cmt_ready = ($urandom_range(2, 0) != 0);
        end else begin
            cmt_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            n_done <= 0;
        end else if (cmt_fire) begin
            n_done <= n_done + 1;
        end
    end

    // head of the expected commit stream
    always @(negedge clk) begin
        exp_pending <= (n_done < cmt_q.size());
        if (n_done < cmt_q.size()) begin
            exp_cmt <= cmt_q[n_done];
        end
    end

    task automatic report_mismatch(string name, logic [43:0] exp_val, logic [43:0] act_val);
        err_count++;
        $display("FAILED %0t %s expected %0h actual %0h", $time, name, exp_val, act_val);
    endtask

    task automatic report_problem(string msg);
        err_count++;
        $display("ERROR %0t %s", $time, msg);
    endtask

    a_sched_active: assert property (@(posedge clk) chk_sched |-> sched_active == exp_active)
        else report_mismatch("sched_active", 44'(exp_active), 44'($sampled(sched_active)));
    a_sched_tmask: assert property (@(posedge clk) chk_sched |-> sched_tmask == exp_tmask)
        else report_mismatch("sched_tmask", 44'(exp_tmask), 44'($sampled(sched_tmask)));
    a_sched_pc: assert property (@(posedge clk) chk_sched |-> sched_pc == exp_pc)
        else report_mismatch("sched_pc", 44'(exp_pc), 44'($sampled(sched_pc)));
    a_cmt_pending: assert property (@(posedge clk) disable iff (!rst_n) cmt_fire |-> exp_pending)
        else report_problem("a commit fired with no accepted request left to retire");
    a_cmt_wid: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_fire |-> cmt_wid == exp_cmt[43:42])
        else report_mismatch("cmt_wid", 44'(exp_cmt[43:42]), 44'($sampled(cmt_wid)));
    a_cmt_tmask: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_fire |-> cmt_tmask == exp_cmt[41:38])
        else report_mismatch("cmt_tmask", 44'(exp_cmt[41:38]), 44'($sampled(cmt_tmask)));
    a_cmt_pc: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_fire |-> cmt_pc == exp_cmt[37:6])
        else report_mismatch("cmt_pc", 44'(exp_cmt[37:6]), 44'($sampled(cmt_pc)));
    a_cmt_rd: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_fire |-> cmt_rd == exp_cmt[5:1])
        else report_mismatch("cmt_rd", 44'(exp_cmt[5:1]), 44'($sampled(cmt_rd)));
    a_cmt_wb: assert property (@(posedge clk) disable iff (!rst_n)
        cmt_fire |-> cmt_wb == exp_cmt[0])
        else report_mismatch("cmt_wb", 44'(exp_cmt[0]), 44'($sampled(cmt_wb)));
    a_ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        (cmt_valid && !cmt_ready) |-> !req_ready)
        else report_problem("req_ready was high while a record waited for commit");

    function automatic gpu_cfg_pkg::wmask_t stalled_model();
        gpu_cfg_pkg::wmask_t s;
        s = '0;
        for (int b = 0; b < gpu_cfg_pkg::num_barriers; b++) begin
            s = s | m_wait[b];
        end
        return s;
    endfunction

    function automatic void apply_model(gpu_op_pkg::gpu_op_e op, gpu_cfg_pkg::wid_t w,
        gpu_cfg_pkg::tmask_t tm, gpu_cfg_pkg::word_t npc, gpu_cfg_pkg::word_t rs1,
        gpu_cfg_pkg::tmask_t cond, gpu_cfg_pkg::word_t rs2);
        gpu_cfg_pkg::tmask_t lanes;
        gpu_cfg_pkg::bar_id_t b;
        gpu_op_pkg::bar_size_t size_m1;
        for (int i = 0; i < gpu_cfg_pkg::num_threads; i++) begin
            lanes[i] = (i < rs1);
        end
        b = rs1[gpu_cfg_pkg::nb_bits-1:0];
        size_m1 = gpu_op_pkg::bar_size_t'(rs2 - 32'd1);
        case (op)
            gpu_op_pkg::op_tmc: begin
                if (lanes == '0 && m_else_valid[w]) begin
                    m_tmask[w] = m_else_mask[w];
                    m_pc[w] = m_else_pc[w];
                    m_else_valid[w] = 1'b0;
                end else begin
                    m_active[w] = |lanes;
                    m_tmask[w] = lanes;
                end
            end
            gpu_op_pkg::op_wspawn: begin
                for (int i = 0; i < gpu_cfg_pkg::num_warps; i++) begin
                    if (i < rs1 && i != int'(w)) begin
                        // a spawned warp runs lane 0 only
                        m_active[i] = 1'b1;
                        m_tmask[i] = gpu_cfg_pkg::tmask_t'(1);
                        m_pc[i] = rs2;
                    end
                end
            end
            gpu_op_pkg::op_split: begin
                if ((tm & cond) != '0 && (tm & ~cond) != '0) begin
                    m_tmask[w] = tm & cond;
                    m_else_mask[w] = tm & ~cond;
                    m_else_pc[w] = npc;
                    m_else_valid[w] = 1'b1;
                end
            end
            default: begin
                if (m_count[b] == size_m1) begin
                    m_count[b] = '0;
                    m_wait[b] = '0;
                end else begin
                    m_count[b] = m_count[b] + 1'b1;
                    m_wait[b][w] = 1'b1;
                end
            end
        endcase
    endfunction

    task automatic issue(gpu_op_pkg::gpu_op_e op, gpu_cfg_pkg::wid_t w, gpu_cfg_pkg::word_t rs1,
        gpu_cfg_pkg::tmask_t cond, gpu_cfg_pkg::word_t rs2);
        logic accepted;
        req_valid = 1'b1;
        req_op = op;
        req_wid = w;
        req_tmask = m_tmask[w];
        req_rs1 = rs1;
        req_cond = cond;
        req_rs2 = rs2;
        req_pc = $urandom();
        req_next_pc = $urandom();
        req_rd = gpu_cfg_pkg::reg_t'($urandom());
        req_wb = 1'($urandom());
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = req_ready;
        end
        cmt_q.push_back({req_wid, req_tmask, req_pc, req_rd, req_wb});
        apply_model(req_op, req_wid, req_tmask, req_next_pc, req_rs1, req_cond, req_rs2);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // wait until every accepted record has committed
    task automatic drain();
        while (n_done != cmt_q.size()) begin
            @(negedge clk);
        end
    endtask

    task automatic check_all();
        gpu_cfg_pkg::wmask_t stl;
        stl = stalled_model();
        for (int w = 0; w < gpu_cfg_pkg::num_warps; w++) begin
            sched_wid = gpu_cfg_pkg::wid_t'(w);
            exp_active = m_active[w] & ~stl[w];
            exp_tmask = m_tmask[w];
            exp_pc = m_pc[w];
            chk_sched = 1'b1;
            @(posedge clk);
            @(negedge clk);
        end
        chk_sched = 1'b0;
    endtask

    task automatic finish_test(string name, int errs_before);
        if (err_count == errs_before) begin
            tests_passed++;
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, err_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        int cnt;
        gpu_cfg_pkg::word_t spawn_pc;
        void'($urandom(32'h5d08_e650));
        clk = 1'b0;
        rst_n = 1'b0;
        req_valid = 1'b0;
        req_op = gpu_op_pkg::op_tmc;
        req_wid = '0;
        req_tmask = '0;
        req_pc = '0;
        req_next_pc = '0;
        req_rd = '0;
        req_wb = 1'b0;
        req_rs1 = '0;
        req_cond = '0;
        req_rs2 = '0;
        cmt_ready = 1'b1;
        sched_wid = '0;
        gaps = 1'b0;
        chk_sched = 1'b0;
        exp_pending = 1'b0;
        err_count = 0;
        tests_passed = 0;
        tests_failed = 0;
        for (int i = 0; i < gpu_cfg_pkg::num_warps; i++) begin
            m_active[i] = (i == 0);
            m_tmask[i] = (i == 0) ? '1 : '0;
            m_pc[i] = (i == 0) ? gpu_op_pkg::reset_pc : '0;
            m_else_valid[i] = 1'b0;
            m_count[i] = '0;
            m_wait[i] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        errs = err_count;
        assert (cmt_valid == 1'b0) else report_mismatch("cmt_valid", 44'd0, 44'(cmt_valid));
        check_all();
        finish_test("reset", errs);

        errs = err_count;
        for (int i = 0; i < 7; i++) begin
            cnt = (i == 2) ? 0 : int'($urandom_range(4, 0));
            issue(gpu_op_pkg::op_tmc, 2'd0, 32'(cnt), '0, $urandom());
            drain();
            check_all();
        end
        issue(gpu_op_pkg::op_tmc, 2'd0, 32'd4, '0, 32'd0);
        drain();
        finish_test("tmc", errs);

        errs = err_count;
        spawn_pc = $urandom() & 32'hffff_fffc;
        issue(gpu_op_pkg::op_wspawn, 2'd0, 32'd4, '0, spawn_pc);
        drain();
        check_all();
        finish_test("wspawn", errs);

        errs = err_count;
        issue(gpu_op_pkg::op_split, 2'd0, 32'd0, '1, 32'd0);
        drain();
        check_all();
        issue(gpu_op_pkg::op_split, 2'd0, 32'd0, gpu_cfg_pkg::tmask_t'($urandom_range(14, 1)), 32'd0);
        drain();
        check_all();
        issue(gpu_op_pkg::op_tmc, 2'd0, 32'd0, '0, 32'd0);
        drain();
        check_all();
        finish_test("split", errs);

        // three warps meet at barrier 1
        errs = err_count;
        issue(gpu_op_pkg::op_bar, 2'd1, 32'd1, '0, 32'd3);
        issue(gpu_op_pkg::op_bar, 2'd2, 32'd1, '0, 32'd3);
        drain();
        check_all();
        issue(gpu_op_pkg::op_bar, 2'd3, 32'd1, '0, 32'd3);
        drain();
        check_all();
        finish_test("barrier", errs);

        errs = err_count;
        gaps <= 1'b1;
        for (int i = 0; i < 24; i++) begin
            if ($urandom_range(1, 0) == 1) begin
                issue(gpu_op_pkg::op_split, gpu_cfg_pkg::wid_t'($urandom()), 32'd0, '1, 32'd0);
            end else begin
                issue(gpu_op_pkg::op_tmc, gpu_cfg_pkg::wid_t'($urandom()), 32'd4, '0, 32'd0);
            end
        end
        drain();
        gaps <= 1'b0;
        // nothing left in the commit stage once all records retired
        assert (cmt_valid == 1'b0)
            else report_mismatch("cmt_valid", 44'd0, 44'(cmt_valid));
        check_all();
        finish_test("backpressure", errs);

        $display("tests passed %0d failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #((len_total + 50) * 40);
        $display("timeout: the tests did not finish in the expected time");
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: compile.f
src/gpu_cfg_pkg.sv
src/gpu_op_pkg.sv
src/gpu_unit.sv
src/warp_state.sv
src/barrier_table.sv
src/gpu_ctl_top.sv
dv/gpu_ctl_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing -Wno-fatal \
    --top-module gpu_ctl_tb -o gpu_ctl_sim -f compile.f

out=$(./obj_dir/gpu_ctl_sim)
echo "$out"

echo "$out" | grep -q "TEST PASS"
